// File: compile.f
hdl/roce_pkg.sv
hdl/roce_csr_regs.sv
hdl/eth_header_insert.sv
hdl/tx_stream_arbiter.sv
hdl/roce_stack_wrapper.sv
dv/roce_stack_wrapper_asserts.sv
dv/roce_stack_wrapper_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module roce_stack_wrapper_tb -Mdir obj_dir -o sim \
  && ./obj_dir/sim | tee sim.log \
  || echo "build or run returned an error"

grep -qx "TEST PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: dv/roce_stack_wrapper_tb.sv
`timescale 1ns/1ps

module roce_stack_wrapper_tb;

  localparam int TMO = 200;

  logic                 clk        = 1'b0;
  logic                 arst_n     = 1'b0;
  logic                 awvalid    = 1'b0;
  logic [31:0]          awaddr     = '0;
  logic                 wvalid     = 1'b0;
  logic [31:0]          wdata      = '0;
  logic [3:0]           wstrb      = '0;
  logic                 bready     = 1'b0;
  logic                 arvalid    = 1'b0;
  logic [31:0]          araddr     = '0;
  logic                 rready     = 1'b0;
  roce_pkg::axis_beat_t roce_beat  = '0;
  logic                 roce_valid = 1'b0;
  roce_pkg::axis_beat_t raw_beat   = '0;
  logic                 raw_valid  = 1'b0;
  logic                 cmac_ready = 1'b1;
  logic                 awready;
  logic                 wready;
  logic                 bvalid;
  logic [1:0]           bresp;
  logic                 arready;
  logic                 rvalid;
  logic [31:0]          rdata;
  logic [1:0]           rresp;
  logic                 roce_ready;
  logic                 raw_ready;
  roce_pkg::axis_beat_t m_beat;
  logic                 m_valid;

  logic                 bp_en  = 1'b0;
  logic [7:0]           lfsr_q = 8'd14;
  roce_pkg::axis_beat_t out_q[$];
  logic [47:0]          my_mac_m;
  logic [47:0]          their_mac_m;
  string                cur_test;
  int                   errors;
  int                   checks;
  int                   err_start;
  int                   tests_run;
  int                   tests_failed;
  int                   seen_roce;
  int                   seen_raw;

  roce_stack_wrapper #(.CNT_W(32)) u_roce_stack_wrapper (
    .axis_aclk_i       (clk),
    .arst_n_i          (arst_n),
    .s_axil_awvalid_i  (awvalid),
    .s_axil_awaddr_i   (awaddr),
    .s_axil_awready_o  (awready),
    .s_axil_wvalid_i   (wvalid),
    .s_axil_wdata_i    (wdata),
    .s_axil_wstrb_i    (wstrb),
    .s_axil_wready_o   (wready),
    .s_axil_bvalid_o   (bvalid),
    .s_axil_bresp_o    (bresp),
    .s_axil_bready_i   (bready),
    .s_axil_arvalid_i  (arvalid),
    .s_axil_araddr_i   (araddr),
    .s_axil_arready_o  (arready),
    .s_axil_rvalid_o   (rvalid),
    .s_axil_rdata_o    (rdata),
    .s_axil_rresp_o    (rresp),
    .s_axil_rready_i   (rready),
    .s_roce_tx_beat_i  (roce_beat),
    .s_roce_tx_valid_i (roce_valid),
    .s_roce_tx_ready_o (roce_ready),
    .s_raw_tx_beat_i   (raw_beat),
    .s_raw_tx_valid_i  (raw_valid),
    .s_raw_tx_ready_o  (raw_ready),
    .m_cmac_tx_beat_o  (m_beat),
    .m_cmac_tx_valid_o (m_valid),
    .m_cmac_tx_ready_i (cmac_ready)
  );

  bind roce_stack_wrapper roce_stack_wrapper_asserts u_asserts (
    .clk_i        (axis_aclk_i),
    .arst_n_i     (arst_n_i),
    .m_beat_i     (m_cmac_tx_beat_o),
    .m_valid_i    (m_cmac_tx_valid_o),
    .m_ready_i    (m_cmac_tx_ready_i),
    .roce_beat_i  (s_roce_tx_beat_i),
    .roce_valid_i (s_roce_tx_valid_i),
    .roce_ready_i (s_roce_tx_ready_o),
    .raw_beat_i   (s_raw_tx_beat_i),
    .raw_valid_i  (s_raw_tx_valid_i),
    .raw_ready_i  (s_raw_tx_ready_o),
    .bvalid_i     (s_axil_bvalid_o),
    .bready_i     (s_axil_bready_i),
    .rvalid_i     (s_axil_rvalid_o),
    .rready_i     (s_axil_rready_i),
    .rdata_i      (s_axil_rdata_o)
  );

  always #4 clk = ~clk;

  // galois lfsr for x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
  endfunction

  // output ready takes one lfsr bit per cycle under back-pressure
  always @(posedge clk) begin
    #1;
    if (bp_en) begin
      lfsr_q     = lfsr_next(lfsr_q);
      cmac_ready = lfsr_q[0];
    end else begin
      cmac_ready = 1'b1;
    end
  end

  // beats that leave the DUT are sampled mid-cycle
  always @(negedge clk) begin
    if (arst_n && m_valid && cmac_ready) out_q.push_back(m_beat);
  end

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s in test %s", what, cur_test);
    $display("TEST FAIL");
    $finish;
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act == exp) else begin
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_beat(input string name, input roce_pkg::axis_beat_t exp,
                            input roce_pkg::axis_beat_t act);
    checks++;
    assert (act == exp) else begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  // every 32-bit word tagged with source, packet, beat and word index
  function automatic roce_pkg::axis_beat_t make_beat(input logic src, input int pkt,
                                                     input int b, input int n);
    roce_pkg::axis_beat_t beat;
    for (int w = 0; w < roce_pkg::AXIS_DATA_W / 32; w++) begin
      beat.tdata[32*w +: 32] = {4'hA, 3'd0, src, pkt[7:0], b[7:0], w[7:0]};
    end
    beat.tlast = (b == n - 1);
    beat.tkeep = '1;
    if (beat.tlast) beat.tkeep = beat.tkeep >> (4 * pkt + 3);
    return beat;
  endfunction

  // header bytes in wire order with byte 0 in tdata[7:0]
  function automatic roce_pkg::axis_beat_t add_header(input roce_pkg::axis_beat_t beat);
    logic [111:0] hdr;
    hdr = {their_mac_m, my_mac_m, 16'h0800};
    for (int k = 0; k < 14; k++) begin
      beat.tdata[8*k +: 8] = hdr[111 - 8*k -: 8];
    end
    return beat;
  endfunction

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
    int wait_n;
    @(posedge clk);
    #1;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    wait_n  = 0;
    @(negedge clk);
    while (!(awready && wready)) begin
      wait_n++;
      if (wait_n > TMO) abort_on_timeout("awready and wready");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    wait_n  = 0;
    @(negedge clk);
    while (!bvalid) begin
      wait_n++;
      if (wait_n > TMO) abort_on_timeout("bvalid");
      @(negedge clk);
    end
    resp = bresp;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int wait_n;
    @(posedge clk);
    #1;
    araddr  = addr;
    arvalid = 1'b1;
    wait_n  = 0;
    @(negedge clk);
    while (!arready) begin
      wait_n++;
      if (wait_n > TMO) abort_on_timeout("arready");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    rready  = 1'b1;
    wait_n  = 0;
    @(negedge clk);
    while (!rvalid) begin
      wait_n++;
      if (wait_n > TMO) abort_on_timeout("rvalid");
      @(negedge clk);
    end
    data = rdata;
    resp = rresp;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  task automatic write_expect(input string name, input logic [31:0] addr,
                              input logic [31:0] data, input logic [3:0] strb,
                              input logic [1:0] exp_resp);
    logic [1:0] resp;
    axil_write(addr, data, strb, resp);
    check_val({name, " bresp"}, 32'(exp_resp), 32'(resp));
  endtask

  task automatic check_reg(input string name, input logic [31:0] addr,
                           input logic [31:0] exp_data, input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(addr, data, resp);
    check_val({name, " rdata"}, exp_data, data);
    check_val({name, " rresp"}, 32'(exp_resp), 32'(resp));
  endtask

  // called at a drive point and returns at the next one
  task automatic send_pkt(input logic src, input int pkt, input int n);
    int wait_n;
    for (int b = 0; b < n; b++) begin
      if (src) begin
        raw_beat  = make_beat(1'b1, pkt, b, n);
        raw_valid = 1'b1;
      end else begin
        roce_beat  = make_beat(1'b0, pkt, b, n);
        roce_valid = 1'b1;
      end
      wait_n = 0;
      @(negedge clk);
      while (!(src ? raw_ready : roce_ready)) begin
        wait_n++;
        if (wait_n > TMO) abort_on_timeout("input ready");
        @(negedge clk);
      end
      @(posedge clk);
      #1;
    end
    if (src) raw_valid = 1'b0;
    else roce_valid = 1'b0;
  endtask

  task automatic collect_pkt(input logic src, input int pkt, input int n, input logic hdr);
    roce_pkg::axis_beat_t got;
    roce_pkg::axis_beat_t exp;
    int                   wait_n;
    for (int b = 0; b < n; b++) begin
      wait_n = 0;
      while (out_q.size() == 0) begin
        @(posedge clk);
        wait_n++;
        if (wait_n > TMO) abort_on_timeout("output beat");
      end
      got = out_q.pop_front();
      exp = make_beat(src, pkt, b, n);
      if (hdr && b == 0) exp = add_header(exp);
      check_beat($sformatf("%s src %0d pkt %0d beat %0d", cur_test, src, pkt, b), exp, got);
    end
    if (src) seen_raw++;
    else seen_roce++;
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    err_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != err_start) tests_failed++;
    $display("test %s finished with %0d errors", cur_test, errors - err_start);
  endtask

  task automatic test_reset();
    begin_test("reset");
    check_val("reset m_valid", 32'd0, 32'(m_valid));
    check_val("reset roce ready", 32'd0, 32'(roce_ready));
    check_val("reset raw ready", 32'd0, 32'(raw_ready));
    check_reg("reset roce count", roce_pkg::CSR_ROCE_PKTS, 32'd0, roce_pkg::RESP_OKAY);
    check_reg("reset raw count", roce_pkg::CSR_RAW_PKTS, 32'd0, roce_pkg::RESP_OKAY);
    end_test();
  endtask

  task automatic test_registers();
    begin_test("registers");
    write_expect("mac lo", roce_pkg::CSR_MAC_LO, 32'h3344_5566, 4'hF, roce_pkg::RESP_OKAY);
    write_expect("mac hi", roce_pkg::CSR_MAC_HI, 32'h0000_1122, 4'h3, roce_pkg::RESP_OKAY);
    write_expect("ipv4", roce_pkg::CSR_IPV4, 32'hC0A8_0A01, 4'hF, roce_pkg::RESP_OKAY);
    write_expect("dmac lo", roce_pkg::CSR_DMAC_LO, 32'hCCDD_EEFF, 4'hF, roce_pkg::RESP_OKAY);
    write_expect("dmac hi", roce_pkg::CSR_DMAC_HI, 32'h0000_AABB, 4'h3, roce_pkg::RESP_OKAY);
    check_reg("mac lo", roce_pkg::CSR_MAC_LO, 32'h3344_5566, roce_pkg::RESP_OKAY);
    check_reg("mac hi", roce_pkg::CSR_MAC_HI, 32'h0000_1122, roce_pkg::RESP_OKAY);
    check_reg("ipv4", roce_pkg::CSR_IPV4, 32'hC0A8_0A01, roce_pkg::RESP_OKAY);
    check_reg("dmac lo", roce_pkg::CSR_DMAC_LO, 32'hCCDD_EEFF, roce_pkg::RESP_OKAY);
    check_reg("dmac hi", roce_pkg::CSR_DMAC_HI, 32'h0000_AABB, roce_pkg::RESP_OKAY);
    // byte 2 only
    write_expect("mac lo strb", roce_pkg::CSR_MAC_LO, 32'h9999_9999, 4'b0100,
                 roce_pkg::RESP_OKAY);
    check_reg("mac lo strb", roce_pkg::CSR_MAC_LO, 32'h3399_5566, roce_pkg::RESP_OKAY);
    my_mac_m    = 48'h1122_3399_5566;
    their_mac_m = 48'hAABB_CCDD_EEFF;
    write_expect("roce count write", roce_pkg::CSR_ROCE_PKTS, 32'h5, 4'hF,
                 roce_pkg::RESP_SLVERR);
    check_reg("roce count kept", roce_pkg::CSR_ROCE_PKTS, 32'd0, roce_pkg::RESP_OKAY);
    check_reg("unmapped", 32'h40, 32'd0, roce_pkg::RESP_SLVERR);
    end_test();
  endtask

  task automatic test_header();
    begin_test("header");
    fork
      send_pkt(1'b0, 0, 3);
      collect_pkt(1'b0, 0, 3, 1'b1);
    join
    end_test();
  endtask

  task automatic test_bypass();
    begin_test("bypass");
    fork
      send_pkt(1'b1, 0, 2);
      collect_pkt(1'b1, 0, 2, 1'b0);
    join
    end_test();
  endtask

  task automatic test_arbitration();
    int roce_len [4];
    int raw_len [4];
    roce_len = '{1, 3, 2, 4};
    raw_len  = '{2, 1, 4, 3};
    begin_test("arbitration");
    bp_en = 1'b1;
    fork
      begin
        for (int i = 0; i < 4; i++) send_pkt(1'b0, 10 + i, roce_len[i]);
      end
      begin
        for (int i = 0; i < 4; i++) send_pkt(1'b1, 10 + i, raw_len[i]);
      end
      // packets alternate with roce first
      begin
        for (int i = 0; i < 4; i++) begin
          collect_pkt(1'b0, 10 + i, roce_len[i], 1'b1);
          collect_pkt(1'b1, 10 + i, raw_len[i], 1'b0);
        end
      end
    join
    bp_en = 1'b0;
    check_val("arbitration leftover beats", 32'd0, 32'(out_q.size()));
    end_test();
  endtask

  task automatic test_counters();
    begin_test("counters");
    check_reg("roce count", roce_pkg::CSR_ROCE_PKTS, 32'(seen_roce), roce_pkg::RESP_OKAY);
    check_reg("raw count", roce_pkg::CSR_RAW_PKTS, 32'(seen_raw), roce_pkg::RESP_OKAY);
    end_test();
  endtask

  initial begin
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    seen_roce    = 0;
    seen_raw     = 0;
    my_mac_m     = '0;
    their_mac_m  = '0;
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;
    test_reset();
    test_registers();
    test_header();
    test_bypass();
    test_arbitration();
    test_counters();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: dv/roce_stack_wrapper_asserts.sv
`timescale 1ns/1ps

module roce_stack_wrapper_asserts (
  input logic                 clk_i,
  input logic                 arst_n_i,
  input roce_pkg::axis_beat_t m_beat_i,
  input logic                 m_valid_i,
  input logic                 m_ready_i,
  input roce_pkg::axis_beat_t roce_beat_i,
  input logic                 roce_valid_i,
  input logic                 roce_ready_i,
  input roce_pkg::axis_beat_t raw_beat_i,
  input logic                 raw_valid_i,
  input logic                 raw_ready_i,
  input logic                 bvalid_i,
  input logic                 bready_i,
  input logic                 rvalid_i,
  input logic                 rready_i,
  input logic [31:0]          rdata_i
);

  logic roce_open_q;
  logic raw_open_q;

  // packet in flight per source, between first beat and tlast
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      roce_open_q <= 1'b0;
      raw_open_q  <= 1'b0;
    end else begin
      if (roce_valid_i && roce_ready_i) roce_open_q <= !roce_beat_i.tlast;
      if (raw_valid_i && raw_ready_i) raw_open_q <= !raw_beat_i.tlast;
    end
  end

  a_out_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (m_valid_i && !m_ready_i) |=> (m_valid_i && $stable(m_beat_i)))
    else $error("output beat changed while stalled");

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (bvalid_i && !bready_i) |=> bvalid_i)
    else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (rvalid_i && !rready_i) |=> (rvalid_i && $stable(rdata_i)))
    else $error("read response dropped or changed before rready");

  a_raw_locked_out: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    roce_open_q |-> !raw_ready_i)
    else $error("raw ready high during a roce packet");

  a_roce_locked_out: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    raw_open_q |-> !roce_ready_i)
    else $error("roce ready high during a raw packet");

endmodule

// File: hdl/roce_stack_wrapper.sv
`timescale 1ns/1ps

module roce_stack_wrapper #(
  parameter int CNT_W = 32
) (
  input  logic                                axis_aclk_i,
  input  logic                                arst_n_i,
  // register bus
  input  logic                                s_axil_awvalid_i,
  input  logic [roce_pkg::AXIL_ADDR_W-1:0]    s_axil_awaddr_i,
  output logic                                s_axil_awready_o,
  input  logic                                s_axil_wvalid_i,
  input  logic [roce_pkg::AXIL_DATA_W-1:0]    s_axil_wdata_i,
  input  logic [roce_pkg::AXIL_DATA_W/8-1:0]  s_axil_wstrb_i,
  output logic                                s_axil_wready_o,
  output logic                                s_axil_bvalid_o,
  output logic [1:0]                          s_axil_bresp_o,
  input  logic                                s_axil_bready_i,
  input  logic                                s_axil_arvalid_i,
  input  logic [roce_pkg::AXIL_ADDR_W-1:0]    s_axil_araddr_i,
  output logic                                s_axil_arready_o,
  output logic                                s_axil_rvalid_o,
  output logic [roce_pkg::AXIL_DATA_W-1:0]    s_axil_rdata_o,
  output logic [1:0]                          s_axil_rresp_o,
  input  logic                                s_axil_rready_i,
  // roce packets, header gets filled in here
  input  roce_pkg::axis_beat_t                s_roce_tx_beat_i,
  input  logic                                s_roce_tx_valid_i,
  output logic                                s_roce_tx_ready_o,
  // non-roce bypass
  input  roce_pkg::axis_beat_t                s_raw_tx_beat_i,
  input  logic                                s_raw_tx_valid_i,
  output logic                                s_raw_tx_ready_o,
  // toward cmac
  output roce_pkg::axis_beat_t                m_cmac_tx_beat_o,
  output logic                                m_cmac_tx_valid_o,
  input  logic                                m_cmac_tx_ready_i
);

  roce_pkg::net_cfg_t   net_cfg;
  roce_pkg::axis_beat_t hdr_beat;
  logic                 hdr_valid;
  logic                 hdr_ready;
  logic [CNT_W-1:0]     roce_pkts;
  logic [CNT_W-1:0]     raw_pkts;

  roce_csr_regs #(
    .CNT_W(CNT_W)
  ) u_csr_regs (
    .clk_i       (axis_aclk_i),
    .arst_n_i    (arst_n_i),
    .awvalid_i   (s_axil_awvalid_i),
    .awaddr_i    (s_axil_awaddr_i),
    .awready_o   (s_axil_awready_o),
    .wvalid_i    (s_axil_wvalid_i),
    .wdata_i     (s_axil_wdata_i),
    .wstrb_i     (s_axil_wstrb_i),
    .wready_o    (s_axil_wready_o),
    .bvalid_o    (s_axil_bvalid_o),
    .bresp_o     (s_axil_bresp_o),
    .bready_i    (s_axil_bready_i),
    .arvalid_i   (s_axil_arvalid_i),
    .araddr_i    (s_axil_araddr_i),
    .arready_o   (s_axil_arready_o),
    .rvalid_o    (s_axil_rvalid_o),
    .rdata_o     (s_axil_rdata_o),
    .rresp_o     (s_axil_rresp_o),
    .rready_i    (s_axil_rready_i),
    .roce_pkts_i (roce_pkts),
    .raw_pkts_i  (raw_pkts),
    .net_cfg_o   (net_cfg)
  );

  eth_header_insert u_eth_header_insert (
    .clk_i     (axis_aclk_i),
    .arst_n_i  (arst_n_i),
    .net_cfg_i (net_cfg),
    .s_beat_i  (s_roce_tx_beat_i),
    .s_valid_i (s_roce_tx_valid_i),
    .s_ready_o (s_roce_tx_ready_o),
    .m_beat_o  (hdr_beat),
    .m_valid_o (hdr_valid),
    .m_ready_i (hdr_ready)
  );

  tx_stream_arbiter #(
    .CNT_W(CNT_W)
  ) u_tx_stream_arbiter (
    .clk_i        (axis_aclk_i),
    .arst_n_i     (arst_n_i),
    .roce_beat_i  (hdr_beat),
    .roce_valid_i (hdr_valid),
    .roce_ready_o (hdr_ready),
    .raw_beat_i   (s_raw_tx_beat_i),
    .raw_valid_i  (s_raw_tx_valid_i),
    .raw_ready_o  (s_raw_tx_ready_o),
    .m_beat_o     (m_cmac_tx_beat_o),
    .m_valid_o    (m_cmac_tx_valid_o),
    .m_ready_i    (m_cmac_tx_ready_i),
    .roce_pkts_o  (roce_pkts),
    .raw_pkts_o   (raw_pkts)
  );

endmodule

// File: hdl/tx_stream_arbiter.sv
`timescale 1ns/1ps

module tx_stream_arbiter #(
  parameter int CNT_W = 32
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  roce_pkg::axis_beat_t roce_beat_i,
  input  logic                 roce_valid_i,
  output logic                 roce_ready_o,
  input  roce_pkg::axis_beat_t raw_beat_i,
  input  logic                 raw_valid_i,
  output logic                 raw_ready_o,
  output roce_pkg::axis_beat_t m_beat_o,
  output logic                 m_valid_o,
  input  logic                 m_ready_i,
  output logic [CNT_W-1:0]     roce_pkts_o,
  output logic [CNT_W-1:0]     raw_pkts_o
);

  roce_pkg::arb_state_e state_q;
  roce_pkg::arb_state_e grant;
  logic                 last_raw_q;
  logic                 xfer;
  logic                 last_xfer;

  // idle picks a new source at once, otherwise the packet keeps its grant
  always_comb begin
    grant = state_q;
    if (state_q == roce_pkg::ARB_IDLE) begin
      if (roce_valid_i && raw_valid_i) begin
        grant = last_raw_q ? roce_pkg::ARB_ROCE : roce_pkg::ARB_RAW;
      end else if (roce_valid_i) begin
        grant = roce_pkg::ARB_ROCE;
      end else if (raw_valid_i) begin
        grant = roce_pkg::ARB_RAW;
      end
    end
  end

  always_comb begin
    case (grant)
      roce_pkg::ARB_ROCE: begin
        m_beat_o  = roce_beat_i;
        m_valid_o = roce_valid_i;
      end
      roce_pkg::ARB_RAW: begin
        m_beat_o  = raw_beat_i;
        m_valid_o = raw_valid_i;
      end
      default: begin
        m_beat_o  = '0;
        m_valid_o = 1'b0;
      end
    endcase
  end

  assign roce_ready_o = (grant == roce_pkg::ARB_ROCE) & m_ready_i;
  assign raw_ready_o  = (grant == roce_pkg::ARB_RAW) & m_ready_i;
  assign xfer         = m_valid_o & m_ready_i;
  assign last_xfer    = xfer & m_beat_o.tlast;

  // last_raw_q starts set so roce wins the first tie
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= roce_pkg::ARB_IDLE;
      last_raw_q  <= 1'b1;
      roce_pkts_o <= '0;
      raw_pkts_o  <= '0;
    end else if (last_xfer) begin
      state_q    <= roce_pkg::ARB_IDLE;
      last_raw_q <= (grant == roce_pkg::ARB_RAW);
      if (grant == roce_pkg::ARB_RAW) raw_pkts_o <= raw_pkts_o + 1'b1;
      else roce_pkts_o <= roce_pkts_o + 1'b1;
    end else begin
      state_q <= grant;
    end
  end

endmodule

// File: hdl/eth_header_insert.sv
`timescale 1ns/1ps

module eth_header_insert (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  roce_pkg::net_cfg_t   net_cfg_i,
  input  roce_pkg::axis_beat_t s_beat_i,
  input  logic                 s_valid_i,
  output logic                 s_ready_o,
  output roce_pkg::axis_beat_t m_beat_o,
  output logic                 m_valid_o,
  input  logic                 m_ready_i
);

  logic first_q;

  // handshake passes straight through
  assign s_ready_o = m_ready_i;
  assign m_valid_o = s_valid_i;

  // next beat opens a packet after reset and after every tlast
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      first_q <= 1'b1;
    end else if (s_valid_i && m_ready_i) begin
      first_q <= s_beat_i.tlast;
    end
  end

  always_comb begin
    m_beat_o = s_beat_i;
    if (first_q) begin
      // byte 0 sits in tdata[7:0], mac msb first
      for (int b = 0; b < 6; b++) begin
        m_beat_o.tdata[8*b +: 8]     = net_cfg_i.their_mac[8*(5-b) +: 8];
        m_beat_o.tdata[8*(b+6) +: 8] = net_cfg_i.my_mac[8*(5-b) +: 8];
      end
      m_beat_o.tdata[8*12 +: 8] = roce_pkg::ETHERTYPE_IPV4[15:8];
      m_beat_o.tdata[8*13 +: 8] = roce_pkg::ETHERTYPE_IPV4[7:0];
    end
  end

endmodule

// File: hdl/roce_csr_regs.sv
`timescale 1ns/1ps

module roce_csr_regs #(
  parameter int CNT_W = 32
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic                                awvalid_i,
  input  logic [roce_pkg::AXIL_ADDR_W-1:0]    awaddr_i,
  output logic                                awready_o,
  input  logic                                wvalid_i,
  input  logic [roce_pkg::AXIL_DATA_W-1:0]    wdata_i,
  input  logic [roce_pkg::AXIL_DATA_W/8-1:0]  wstrb_i,
  output logic                                wready_o,
  output logic                                bvalid_o,
  output logic [1:0]                          bresp_o,
  input  logic                                bready_i,
  input  logic                                arvalid_i,
  input  logic [roce_pkg::AXIL_ADDR_W-1:0]    araddr_i,
  output logic                                arready_o,
  output logic                                rvalid_o,
  output logic [roce_pkg::AXIL_DATA_W-1:0]    rdata_o,
  output logic [1:0]                          rresp_o,
  input  logic                                rready_i,
  input  logic [CNT_W-1:0]                    roce_pkts_i,
  input  logic [CNT_W-1:0]                    raw_pkts_i,
  output roce_pkg::net_cfg_t                  net_cfg_o
);

  roce_pkg::mac_addr_t              my_mac_q;
  roce_pkg::mac_addr_t              their_mac_q;
  roce_pkg::ip_addr_t               ipv4_q;
  logic                             bvalid_q;
  logic                             rvalid_q;
  logic                             wr_fire;
  logic                             rd_fire;
  logic                             wr_ok;
  logic [roce_pkg::AXIL_DATA_W-1:0] wr_merged;

  // current register contents, zero-extended; unmapped reads as zero
  function automatic logic [roce_pkg::AXIL_DATA_W-1:0] csr_value(
    input logic [roce_pkg::AXIL_ADDR_W-1:0] addr
  );
    logic [roce_pkg::AXIL_DATA_W-1:0] val;
    val = '0;
    case (roce_pkg::csr_addr_e'(addr))
      roce_pkg::CSR_MAC_LO:    val = my_mac_q[31:0];
      roce_pkg::CSR_MAC_HI:    val[15:0] = my_mac_q[47:32];
      roce_pkg::CSR_IPV4:      val = ipv4_q;
      roce_pkg::CSR_DMAC_LO:   val = their_mac_q[31:0];
      roce_pkg::CSR_DMAC_HI:   val[15:0] = their_mac_q[47:32];
      roce_pkg::CSR_ROCE_PKTS: val[CNT_W-1:0] = roce_pkts_i;
      roce_pkg::CSR_RAW_PKTS:  val[CNT_W-1:0] = raw_pkts_i;
      default:                 val = '0;
    endcase
    return val;
  endfunction

  function automatic logic csr_writable(input logic [roce_pkg::AXIL_ADDR_W-1:0] addr);
    case (roce_pkg::csr_addr_e'(addr))
      roce_pkg::CSR_MAC_LO, roce_pkg::CSR_MAC_HI, roce_pkg::CSR_IPV4,
      roce_pkg::CSR_DMAC_LO, roce_pkg::CSR_DMAC_HI: return 1'b1;
      default:                                     return 1'b0;
    endcase
  endfunction

  function automatic logic csr_readable(input logic [roce_pkg::AXIL_ADDR_W-1:0] addr);
    case (roce_pkg::csr_addr_e'(addr))
      roce_pkg::CSR_ROCE_PKTS, roce_pkg::CSR_RAW_PKTS: return 1'b1;
      default:                                         return csr_writable(addr);
    endcase
  endfunction

  // address and data accepted together
  assign wr_fire   = awvalid_i & wvalid_i & ~bvalid_q;
  assign awready_o = wr_fire;
  assign wready_o  = wr_fire;
  assign wr_ok     = csr_writable(awaddr_i);
  assign rd_fire   = arvalid_i & ~rvalid_q;
  assign arready_o = rd_fire;
  assign bvalid_o  = bvalid_q;
  assign rvalid_o  = rvalid_q;

  always_comb begin
    wr_merged = csr_value(awaddr_i);
    for (int b = 0; b < roce_pkg::AXIL_DATA_W / 8; b++) begin
      if (wstrb_i[b]) wr_merged[8*b +: 8] = wdata_i[8*b +: 8];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      my_mac_q    <= '0;
      their_mac_q <= '0;
      ipv4_q      <= '0;
    end else if (wr_fire && wr_ok) begin
      case (roce_pkg::csr_addr_e'(awaddr_i))
        roce_pkg::CSR_MAC_LO:  my_mac_q[31:0]     <= wr_merged;
        roce_pkg::CSR_MAC_HI:  my_mac_q[47:32]    <= wr_merged[15:0];
        roce_pkg::CSR_IPV4:    ipv4_q             <= wr_merged;
        roce_pkg::CSR_DMAC_LO: their_mac_q[31:0]  <= wr_merged;
        roce_pkg::CSR_DMAC_HI: their_mac_q[47:32] <= wr_merged[15:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_fire) bvalid_q <= 1'b1;
      else if (bready_i) bvalid_q <= 1'b0;
      if (rd_fire) rvalid_q <= 1'b1;
      else if (rready_i) rvalid_q <= 1'b0;
    end
  end

  // response payload, held until accepted
  always_ff @(posedge clk_i) begin
    if (wr_fire) bresp_o <= wr_ok ? roce_pkg::RESP_OKAY : roce_pkg::RESP_SLVERR;
    if (rd_fire) begin
      rdata_o <= csr_value(araddr_i);
      rresp_o <= csr_readable(araddr_i) ? roce_pkg::RESP_OKAY : roce_pkg::RESP_SLVERR;
    end
  end

  assign net_cfg_o.my_mac    = my_mac_q;
  assign net_cfg_o.their_mac = their_mac_q;

endmodule

// File: hdl/roce_pkg.sv
package roce_pkg;

  // stream and register bus widths
  localparam int AXIS_DATA_W = 512;
  localparam int AXIS_KEEP_W = AXIS_DATA_W / 8;
  localparam int AXIL_ADDR_W = 32;
  localparam int AXIL_DATA_W = 32;

  // most significant byte goes first on the wire
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;

  typedef struct packed {
    logic [AXIS_DATA_W-1:0] tdata;
    logic [AXIS_KEEP_W-1:0] tkeep;
    logic                   tlast;
  } axis_beat_t;

  typedef struct packed {
    mac_addr_t my_mac;
    mac_addr_t their_mac;
  } net_cfg_t;

  // register offsets
  typedef enum logic [AXIL_ADDR_W-1:0] {
    CSR_MAC_LO    = 32'h04,
    CSR_MAC_HI    = 32'h08,
    CSR_IPV4      = 32'h0C,
    CSR_DMAC_LO   = 32'h10,
    CSR_DMAC_HI   = 32'h14,
    CSR_ROCE_PKTS = 32'h20,
    CSR_RAW_PKTS  = 32'h24
  } csr_addr_e;

  typedef enum logic [1:0] {ARB_IDLE, ARB_ROCE, ARB_RAW} arb_state_e;

  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [1:0]  RESP_OKAY      = 2'd0;
  localparam logic [1:0]  RESP_SLVERR    = 2'd2;

endpackage
